/* synth_pkg.sv */
// Shared widths, types and constants for the two-voice synth core.
// Imported by every RTL module and by the testbench.
package synth_pkg;

	// ----------------------------------------
	// sample format
	// ----------------------------------------
	localparam int SAMPLE_W = 16;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// ----------------------------------------
	// additive voice
	// ----------------------------------------
	localparam int ROM_ADDR_W   = 6;              // quarter table, 64 entries
	localparam int PHASE_W      = 8;              // 256 steps per period
	localparam int NUM_PARTIALS = 4;
	localparam int PART_W       = $clog2(NUM_PARTIALS);
	localparam int WEIGHT_W     = 3;
	localparam int MIX_SHIFT    = 4;              // sum of weights is 12, /16 keeps headroom
	localparam int ADD_ACC_W    = SAMPLE_W + 4;   // 12 * full scale fits

	// harmonic h uses entry h-1
	localparam logic [WEIGHT_W-1:0] PARTIAL_WEIGHT [NUM_PARTIALS] = '{3'd6, 3'd3, 3'd2, 3'd1};

	typedef enum logic [1:0] {
		ADD_IDLE,   // result held, waiting for the serializer
		ADD_READ,   // table read of one partial
		ADD_ACCUM,  // weight and add
		ADD_DONE    // scale into the output register
	} add_state_t;

	// ----------------------------------------
	// cordic voice
	// ----------------------------------------
	localparam int CORDIC_W         = 12;
	localparam int CORDIC_ITER      = 11;
	localparam int CORDIC_ANGLE_W   = 32;
	localparam int CORDIC_OUT_SHIFT = SAMPLE_W - CORDIC_W;
	localparam logic signed [CORDIC_W-1:0] CORDIC_X0 = 12'sd607;   // 1000 / gain

	// atan(2^-i), full turn = 2^32
	localparam logic signed [CORDIC_ANGLE_W-1:0] CORDIC_ATAN [CORDIC_ITER] = '{
		32'h2000_0000, 32'h12E4_051D, 32'h09FB_385B, 32'h0511_11D4,
		32'h028B_0D43, 32'h0145_D7E1, 32'h00A2_F61E, 32'h0051_7C55,
		32'h0028_BE53, 32'h0014_5F2E, 32'h000A_2F98
	};

	// ----------------------------------------
	// serializer timing
	// ----------------------------------------
	localparam int BCK_HALF    = 2;                      // clk cycles per bck half
	localparam int BCK_DIV_W   = $clog2(2 * BCK_HALF);
	localparam int BITS_PER_CH = 16;
	localparam int FRAME_BITS  = 2 * BITS_PER_CH;        // left word then right word
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

endpackage

/* additive_voice.sv */
// Additive voice: four harmonic partials from one quarter-wave sine ROM,
// read one after another and summed with weights 6/3/2/1, scaled by 1/16.
// Hands each sample to the serializer over a valid/ready link.
module additive_voice
	import synth_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic [PHASE_W-1:0] step,    // phase increment per sample
	output sample_t            sample,
	output logic               valid,
	input  logic               ready
);

	add_state_t                    state;
	logic [PHASE_W-1:0]            phase;       // fundamental phase
	logic [PART_W-1:0]             part;        // partial index, harmonic = part+1
	logic [PHASE_W-1:0]            harm;
	logic [PHASE_W-1:0]            part_phase;
	logic [ROM_ADDR_W-1:0]         rom_idx;
	sample_t                       sine_rom [2**ROM_ADDR_W];
	sample_t                       rom_q;
	logic                          neg_q;
	sample_t                       term;
	logic signed [ADD_ACC_W-1:0]   acc;

	initial begin
		$readmemh("sine_table.hex", sine_rom);
	end

	// ----------------------------------------
	// address of the current partial
	// ----------------------------------------
	assign harm       = PHASE_W'(part) + 1'b1;
	assign part_phase = phase * harm;            // wraps mod 256
	// odd quarters run the table backwards
	assign rom_idx    = part_phase[PHASE_W-2] ? ~part_phase[ROM_ADDR_W-1:0]
	                                          :  part_phase[ROM_ADDR_W-1:0];
	assign term       = neg_q ? -rom_q : rom_q;  // second half is negative

	// ----------------------------------------
	// sequencer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ADD_READ;   // sample 0 at phase 0 starts right away
			phase <= '0;
			part  <= '0;
			acc   <= '0;
			valid <= 1'b0;
		end else begin
			case (state)
				ADD_IDLE: begin
					if (valid && ready) begin
						phase <= phase + step;   // next sample
						part  <= '0;
						acc   <= '0;
						valid <= 1'b0;
						state <= ADD_READ;
					end else begin
						valid <= 1'b1;           // output reg settled in DONE
					end
				end
				ADD_READ: state <= ADD_ACCUM;
				ADD_ACCUM: begin
					acc <= acc + term * $signed({1'b0, PARTIAL_WEIGHT[part]});
					if (part == PART_W'(NUM_PARTIALS - 1)) begin
						state <= ADD_DONE;
					end else begin
						part  <= part + 1'b1;
						state <= ADD_READ;
					end
				end
				ADD_DONE: state <= ADD_IDLE;
				default:  state <= ADD_IDLE;
			endcase
		end
	end

	// table read and output register
	always_ff @(posedge clk) begin
		if (state == ADD_READ) begin
			rom_q <= sine_rom[rom_idx];
			neg_q <= part_phase[PHASE_W-1];
		end
		if (state == ADD_DONE) begin
			sample <= sample_t'(acc >>> MIX_SHIFT);   // arithmetic, keeps sign
		end
	end

endmodule

/* cordic_voice.sv */
// CORDIC sine voice: phase accumulator, quadrant fold and an 11 stage
// rotation pipeline. Output is the 12 bit sine scaled up to 16 bits,
// handed to the serializer over valid/ready.
module cordic_voice
	import synth_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [CORDIC_ANGLE_W-1:0] step,   // angle increment per sample
	output sample_t                   sample,
	output logic                      valid,
	input  logic                      ready
);

	localparam int LAST = CORDIC_ITER - 1;

	logic [CORDIC_ANGLE_W-1:0]        angle;
	logic                             start;      // one item enters the fold stage
	logic [CORDIC_ITER-1:0]           stg_v;      // stg_v[i] set while x/y/z[i] hold the item
	logic signed [CORDIC_W:0]         x_q [CORDIC_ITER];   // one guard bit
	logic signed [CORDIC_W:0]         y_q [CORDIC_ITER];
	logic signed [CORDIC_ANGLE_W-1:0] z_q [CORDIC_ITER];   // residual angle
	logic signed [CORDIC_W-1:0]       y_last;

	assign sample = {y_last, {CORDIC_OUT_SHIFT{1'b0}}};

	// ----------------------------------------
	// accumulator and item tracking
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			angle <= '0;
			start <= 1'b1;   // sample 0 at angle 0
			stg_v <= '0;
			valid <= 1'b0;
		end else begin
			start <= valid && ready;
			stg_v <= {stg_v[CORDIC_ITER-2:0], start};
			if (valid && ready) begin
				angle <= angle + step;
				valid <= 1'b0;
			end else if (stg_v[LAST]) begin
				valid <= 1'b1;   // y_last written this edge
			end
		end
	end

	// ----------------------------------------
	// fold and rotation stages
	// ----------------------------------------
	always_ff @(posedge clk) begin
		// bring the angle into -pi/2..pi/2, start vector (x0, 0)
		if (start) begin
			case (angle[CORDIC_ANGLE_W-1 -: 2])
				2'b01: begin   // second quarter, rotate start by +90
					x_q[0] <= '0;
					y_q[0] <= CORDIC_X0;
					z_q[0] <= {2'b00, angle[CORDIC_ANGLE_W-3:0]};
				end
				2'b10: begin   // third quarter, rotate start by -90
					x_q[0] <= '0;
					y_q[0] <= -CORDIC_X0;
					z_q[0] <= {2'b11, angle[CORDIC_ANGLE_W-3:0]};
				end
				default: begin
					x_q[0] <= CORDIC_X0;
					y_q[0] <= '0;
					z_q[0] <= angle;
				end
			endcase
		end

		for (int i = 0; i < LAST; i++) begin
			if (stg_v[i]) begin
				if (z_q[i][CORDIC_ANGLE_W-1]) begin   // overshot, turn back
					x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
					y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
					z_q[i+1] <= z_q[i] + CORDIC_ATAN[i];
				end else begin
					x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
					y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
					z_q[i+1] <= z_q[i] - CORDIC_ATAN[i];
				end
			end
		end

		// last stage only needs y
		if (stg_v[LAST]) begin
			if (z_q[LAST][CORDIC_ANGLE_W-1])
				y_last <= CORDIC_W'(y_q[LAST] - (x_q[LAST] >>> LAST));
			else
				y_last <= CORDIC_W'(y_q[LAST] + (x_q[LAST] >>> LAST));
		end
	end

endmodule

/* i2s_serializer.sv */
// I2S style framer for a PCM5102 class DAC. 16 bit left word (lrck low)
// then 16 bit right word (lrck high), MSB first, bck = clk / (2*BCK_HALF).
// Takes one sample per voice at the last clk cycle of each frame.
module i2s_serializer
	import synth_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  sample_t left_sample,
	input  logic    left_valid,
	output logic    left_ready,
	input  sample_t right_sample,
	input  logic    right_valid,
	output logic    right_ready,
	output logic    bck,
	output logic    lrck,
	output logic    din
);

	logic [BCK_DIV_W-1:0]   div_cnt;      // position inside one bit
	logic [FRAME_CNT_W-1:0] bit_cnt;      // bit of the frame, 0 = left MSB
	logic                   bit_end;
	logic                   frame_end;
	sample_t                left_hold;    // last accepted samples
	sample_t                right_hold;
	sample_t                left_next;
	sample_t                right_next;
	logic [FRAME_BITS-1:0]  shift_q;

	assign bit_end   = (div_cnt == BCK_DIV_W'(2 * BCK_HALF - 1));
	assign frame_end = bit_end && (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1));

	assign left_ready  = frame_end;   // one cycle per frame
	assign right_ready = frame_end;

	// resend the old word if a voice is late
	assign left_next  = left_valid  ? left_sample  : left_hold;
	assign right_next = right_valid ? right_sample : right_hold;

	// ----------------------------------------
	// bit and frame counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
			if (frame_end)
				bit_cnt <= '0;
			else if (bit_end)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// load at frame end, shift at every other bit end
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			left_hold  <= '0;
			right_hold <= '0;
			shift_q    <= '0;   // frame 0 is silent
		end else if (frame_end) begin
			left_hold  <= left_next;
			right_hold <= right_next;
			shift_q    <= {left_next, right_next};
		end else if (bit_end) begin
			shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
		end
	end

	// din moves on the bck falling edge, stable through the high half
	assign bck  = (div_cnt >= BCK_DIV_W'(BCK_HALF));
	assign lrck = (bit_cnt >= FRAME_CNT_W'(BITS_PER_CH));
	assign din  = shift_q[FRAME_BITS-1];

endmodule

/* synth_top.sv */
// Top level of the synth core: additive voice on the left channel,
// CORDIC voice on the right, both framed out to the DAC pins.
module synth_top
	import synth_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [PHASE_W-1:0]        add_step,    // left pitch
	input  logic [CORDIC_ANGLE_W-1:0] sine_step,   // right pitch
	output logic                      bck,
	output logic                      lrck,
	output logic                      din
);

	sample_t left_sample;
	logic    left_valid;
	logic    left_ready;
	sample_t right_sample;
	logic    right_valid;
	logic    right_ready;

	additive_voice u_additive (
		.clk    (clk),
		.rst_n  (rst_n),
		.step   (add_step),
		.sample (left_sample),
		.valid  (left_valid),
		.ready  (left_ready)
	);

	cordic_voice u_cordic (
		.clk    (clk),
		.rst_n  (rst_n),
		.step   (sine_step),
		.sample (right_sample),
		.valid  (right_valid),
		.ready  (right_ready)
	);

	i2s_serializer u_serializer (
		.clk          (clk),
		.rst_n        (rst_n),
		.left_sample  (left_sample),
		.left_valid   (left_valid),
		.left_ready   (left_ready),
		.right_sample (right_sample),
		.right_valid  (right_valid),
		.right_ready  (right_ready),
		.bck          (bck),
		.lrck         (lrck),
		.din          (din)
	);

endmodule

/* tb_checker.sv */
// Watches the DAC pins of the synth core, rebuilds every frame from bck/lrck/din
// and compares both words with a model of the two voices.
module tb_checker
	import synth_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      bck,
	input  logic                      lrck,
	input  logic                      din,
	input  logic [PHASE_W-1:0]        add_step,
	input  logic [CORDIC_ANGLE_W-1:0] sine_step,
	output int                        frames_done,
	output int                        left_errs,
	output int                        right_errs,
	output int                        frame_errs
);
	timeunit 1ns;
	timeprecision 100ps;

	sample_t                   rom [2**ROM_ADDR_W];   // same quarter table as the DUT
	logic                      bck_q;
	logic                      din_q;
	logic                      lr_cur;                // lrck half being collected
	int                        half_bits;
	int                        frame_idx;
	sample_t                   left_word;
	sample_t                   right_word;
	logic [PHASE_W-1:0]        add_ph;                // phase of the next expected sample
	logic [PHASE_W-1:0]        add_prev;              // step taken at the last load
	logic [CORDIC_ANGLE_W-1:0] sine_ang;
	logic [CORDIC_ANGLE_W-1:0] sine_prev;

	initial begin
		$readmemh("sine_table.hex", rom);
		frames_done = 0;
		left_errs   = 0;
		right_errs  = 0;
		frame_errs  = 0;
	end

	// ----------------------------------------
	// voice models
	// ----------------------------------------
	function automatic sample_t additive_model(input logic [PHASE_W-1:0] phase);
		int                    acc;
		int                    val;
		logic [PHASE_W-1:0]    p;
		logic [ROM_ADDR_W-1:0] idx;
		acc = 0;
		for (int h = 1; h <= NUM_PARTIALS; h++) begin
			p   = PHASE_W'(int'(phase) * h);            // harmonic phase mod 256
			idx = p[ROM_ADDR_W-1:0];
			if (p[ROM_ADDR_W])                          // 2nd and 4th quarter mirrored
				idx = ROM_ADDR_W'(2**ROM_ADDR_W - 1 - int'(idx));
			val = int'(rom[idx]);
			if (p[PHASE_W-1])
				val = -val;                             // second half negative
			acc += val * int'(PARTIAL_WEIGHT[h-1]);
		end
		return sample_t'(acc >>> MIX_SHIFT);
	endfunction

	function automatic sample_t cordic_model(input logic [CORDIC_ANGLE_W-1:0] angle);
		int                               x;
		int                               y;
		int                               x_old;
		logic signed [CORDIC_ANGLE_W-1:0] z;
		logic signed [CORDIC_W-1:0]       y_out;
		case (angle[CORDIC_ANGLE_W-1 -: 2])
			2'b01: begin   // start vector already turned +90 deg
				x = 0;
				y = int'(CORDIC_X0);
				z = angle - 32'h4000_0000;
			end
			2'b10: begin   // start vector turned -90 deg
				x = 0;
				y = -int'(CORDIC_X0);
				z = angle + 32'h4000_0000;
			end
			default: begin
				x = int'(CORDIC_X0);
				y = 0;
				z = angle;
			end
		endcase
		for (int i = 0; i < CORDIC_ITER; i++) begin
			x_old = x;
			if (z < 0) begin
				x = x + (y >>> i);
				y = y - (x_old >>> i);
				z = z + CORDIC_ATAN[i];
			end else begin
				x = x - (y >>> i);
				y = y + (x_old >>> i);
				z = z - CORDIC_ATAN[i];
			end
		end
		y_out = CORDIC_W'(y);
		return sample_t'({y_out, {CORDIC_OUT_SHIFT{1'b0}}});
	endfunction

	// ----------------------------------------
	// frame decode and compare
	// ----------------------------------------
	task automatic reset_model();
		lr_cur     = 1'b0;
		half_bits  = 0;
		frame_idx  = 0;
		left_word  = '0;
		right_word = '0;
		add_ph     = '0;
		add_prev   = '0;
		sine_ang   = '0;
		sine_prev  = '0;
	endtask

	task automatic close_frame();
		sample_t left_exp;
		sample_t right_exp;
		if (frame_idx == 0) begin
			left_exp  = '0;                         // silent first frame
			right_exp = '0;
		end else begin
			left_exp  = additive_model(add_ph);     // sample frame_idx-1
			right_exp = cordic_model(sine_ang);
			add_ph    = add_ph + add_prev;
			sine_ang  = sine_ang + sine_prev;
		end
		add_prev  = add_step;                       // steps seen at this frame's load
		sine_prev = sine_step;
		if (left_word !== left_exp) begin
			left_errs++;
			$display("Mismatch at %0t: frame %0d left expected %h got %h",
				$time, frame_idx, left_exp, left_word);
		end
		if (right_word !== right_exp) begin
			right_errs++;
			$display("Mismatch at %0t: frame %0d right expected %h got %h",
				$time, frame_idx, right_exp, right_word);
		end
		frame_idx++;
		frames_done = frame_idx;
	endtask

	task automatic take_bit();
		if (lrck != lr_cur) begin
			if (half_bits != BITS_PER_CH) begin
				frame_errs++;
				$display("framing error at %0t: %0d bits in one lrck half instead of %0d",
					$time, half_bits, BITS_PER_CH);
			end
			if (lr_cur)
				close_frame();   // high to low ends a frame
			lr_cur    = lrck;
			half_bits = 0;
		end
		if (lrck)
			right_word = {right_word[SAMPLE_W-2:0], din};
		else
			left_word = {left_word[SAMPLE_W-2:0], din};
		half_bits++;
	endtask

	// mid-cycle sampling, pins are settled here
	always @(negedge clk) begin
		if (!rst_n) begin
			reset_model();
		end else begin
			if (bck && bck_q && din !== din_q) begin
				frame_errs++;
				$display("framing error at %0t: din changed while bck was high", $time);
			end
			if (bck && !bck_q)
				take_bit();      // bck rise
		end
		bck_q = bck;
		din_q = din;
	end

endmodule

/* tb_synth.sv */
// Testbench top for the synth core. Drives clock, reset and random pitch
// steps, and ends the run once the checker has seen enough frames.
module tb_synth
	import synth_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          NUM_FRAMES   = 200;
	localparam int          FRAME_CYCLES = 2 * BCK_HALF * FRAME_BITS;    // 128 clk
	localparam int          MAX_CYCLES   = NUM_FRAMES * FRAME_CYCLES + 200;
	localparam int          RESET_CYCLES = 10;
	localparam int          STEP_DELAY   = 8;      // clk cycles after lrck rise
	localparam int          FLAT_FIRST   = 120;    // frames with zero steps
	localparam int          FLAT_LAST    = 139;
	localparam logic [31:0] SEED         = 32'hb54f7a6c;

	logic                      clk;
	logic                      rst_n;
	logic [PHASE_W-1:0]        add_step;
	logic [CORDIC_ANGLE_W-1:0] sine_step;
	logic                      bck;
	logic                      lrck;
	logic                      din;
	int                        cycles = 0;
	int                        frames_done;
	int                        left_errs;
	int                        right_errs;
	int                        frame_errs;

	synth_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.add_step  (add_step),
		.sine_step (sine_step),
		.bck       (bck),
		.lrck      (lrck),
		.din       (din)
	);

	tb_checker scoreboard (
		.clk         (clk),
		.rst_n       (rst_n),
		.bck         (bck),
		.lrck        (lrck),
		.din         (din),
		.add_step    (add_step),
		.sine_step   (sine_step),
		.frames_done (frames_done),
		.left_errs   (left_errs),
		.right_errs  (right_errs),
		.frame_errs  (frame_errs)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	always @(posedge clk) cycles <= cycles + 1;

	// new pitch once per frame, mid right half, so it is stable at the load
	task automatic drive_steps(input int frame);
		if (frame >= FLAT_FIRST && frame <= FLAT_LAST) begin
			add_step  = '0;   // held pitch, both outputs go flat
			sine_step = '0;
		end else begin
			add_step  = PHASE_W'($urandom());
			sine_step = $urandom();
		end
	endtask

	initial begin : stimulus
		int frame;
		frame = 0;
		void'($urandom(SEED));   // same step sequence every run
		@(posedge rst_n);
		forever begin
			@(posedge lrck);
			repeat (STEP_DELAY) @(posedge clk);
			#1;
			drive_steps(frame);
			frame++;
		end
	end

	// ----------------------------------------
	// reset, run and verdict
	// ----------------------------------------
	initial begin
		rst_n     = 1'b0;
		add_step  = '0;
		sine_step = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
		while (frames_done < NUM_FRAMES && cycles < MAX_CYCLES)
			@(posedge clk);
		$display("errors: left %0d, right %0d, framing %0d over %0d frames",
			left_errs, right_errs, frame_errs, frames_done);
		if (frames_done >= NUM_FRAMES && left_errs + right_errs + frame_errs == 0) begin
			$display("TEST PASS");
		end else begin
			if (frames_done < NUM_FRAMES)
				$display("timeout after %0d cycles with only %0d of %0d frames decoded",
					cycles, frames_done, NUM_FRAMES);
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* sine_table.hex */
// one signed 16-bit hex word per line holding 32767*sin((i+0.5)*pi/128) for entry i
0192
04B6
07D9
0AFB
0E1C
113A
1455
176E
1A82
1D93
209F
23A6
26A8
29A4
2C99
2F87
326E
354D
3824
3AF3
3DB8
4073
4325
45CD
4869
4AFB
4D81
4FFB
5268
54C9
571D
5964
5B9C
5DC7
5FE3
61F0
63EE
65DD
67BC
698B
6B4A
6CF8
6E96
7022
719D
7307
745F
75A5
76D8
77FA
7909
7A05
7AEE
7BC5
7C88
7D38
7DD5
7E5F
7ED5
7F37
7F86
7FC1
7FE9
7FFD

/* compile.f */
synth_pkg.sv
additive_voice.sv
cordic_voice.sv
i2s_serializer.sv
synth_top.sv
tb_checker.sv
tb_synth.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the synth testbench with Verilator and run it; exit status follows the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	-f compile.f --top-module tb_synth \
	|| { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_synth)"
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1
